//--- recovery_top.f
src/recovery_proto_pkg.sv
src/recovery_bus_pkg.sv
src/recovery_receiver.sv
src/recovery_rx_queue.sv
src/recovery_regfile.sv
src/recovery_executor.sv
src/recovery_top.sv
tests/recovery_top_tb.sv

//--- src/recovery_bus_pkg.sv
// Recovery bus types: commands, payload words and stream bytes between blocks
`default_nettype none

package recovery_bus_pkg;

  // Host-side input byte with frame marker
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } rec_in_byte_t;

  // Decoded command, held by the receiver during execution
  typedef struct packed {
    recovery_proto_pkg::rec_cmd_e code;
    logic                         is_rd;
    logic [15:0]                  len;
    logic                         len_err;
  } rec_cmd_t;

  // Payload word, little-endian byte order
  typedef struct packed {
    logic [31:0] data;
  } rec_word_t;

  // Response byte
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } rec_res_byte_t;

endpackage

`default_nettype wire

//--- src/recovery_executor.sv
// Recovery executor: runs commands against the register file and streams reads
`default_nettype none

module recovery_executor (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                cmd_valid_i,
  input  recovery_bus_pkg::rec_cmd_t          cmd_i,
  output logic                                cmd_done_o,
  output logic                                rx_req_o,
  input  logic                                rx_ack_i,
  input  recovery_bus_pkg::rec_word_t         rx_word_i,
  output logic                                rx_clr_o,
  output logic                                reg_we_o,
  output recovery_proto_pkg::rec_csr_e        reg_wsel_o,
  output logic [31:0]                         reg_wdata_o,
  output recovery_proto_pkg::rec_csr_e        reg_rsel_o,
  input  logic [31:0]                         reg_rdata_i,
  output logic                                res_valid_o,
  input  logic                                res_ready_i,
  output logic [15:0]                         res_len_o,
  output logic                                res_dvalid_o,
  input  logic                                res_dready_i,
  output recovery_bus_pkg::rec_res_byte_t     res_byte_o,
  input  logic                                payload_ack_i,
  output logic                                payload_available_o
);
  import recovery_proto_pkg::*;
  import recovery_bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_POP,
    ST_RD_LEN,
    ST_RD_DATA,
    ST_ERR,
    ST_DONE
  } state_e;

  state_e      state_q, state_d;
  rec_csr_e    csr;
  rec_status_e status;
  logic        err;
  logic        writable;
  logic        fifo_wr;
  logic [15:0] nwords;
  logic [15:0] wcnt_q;
  logic [1:0]  bcnt_q;
  logic        req_q;
  logic        pavail_q;
  logic        word_taken;
  logic        byte_taken;

  // Command is held stable by the receiver, so decode stays combinational
  always_comb begin
    unique case (cmd_i.code)
      CMD_PROT_CAP:           csr = CSR_PROT_CAP;
      CMD_DEVICE_STATUS:      csr = CSR_DEVICE_STATUS;
      CMD_RECOVERY_CTRL:      csr = CSR_RECOVERY_CTRL;
      CMD_INDIRECT_FIFO_CTRL: csr = CSR_INDIRECT_FIFO_CTRL;
      CMD_INDIRECT_FIFO_DATA: csr = CSR_INDIRECT_FIFO_DATA;
      default:                csr = CSR_INVALID;
    endcase
  end

  assign writable = (csr == CSR_RECOVERY_CTRL) | (csr == CSR_INDIRECT_FIFO_CTRL) |
                    (csr == CSR_INDIRECT_FIFO_DATA);
  assign fifo_wr  = ~cmd_i.is_rd & (csr == CSR_INDIRECT_FIFO_DATA);
  // Payload words, rounded up
  assign nwords   = {2'b00, cmd_i.len[15:2]} + {15'd0, |cmd_i.len[1:0]};

  // Protocol status, first matching rule wins
  always_comb begin
    status = PROTOCOL_OK;
    err    = 1'b0;
    if (cmd_i.len_err) begin
      status = PROTOCOL_ERROR_LENGTH;
      err    = 1'b1;
    end else if (csr == CSR_INVALID) begin
      status = PROTOCOL_ERROR_PARAMETER;
      err    = 1'b1;
    end else if (!cmd_i.is_rd && !writable) begin
      // Read-only target, payload is popped and discarded
      status = PROTOCOL_ERROR_READ_ONLY;
    end else if (!cmd_i.is_rd && csr != CSR_INDIRECT_FIFO_DATA &&
                 cmd_i.len != 16'(REG_BYTES)) begin
      status = PROTOCOL_ERROR_LENGTH;
      err    = 1'b1;
    end else if (cmd_i.is_rd && csr == CSR_INDIRECT_FIFO_DATA) begin
      status = PROTOCOL_ERROR_PARAMETER;
      err    = 1'b1;
    end
  end

  assign word_taken = (state_q == ST_WR_POP) & req_q & rx_ack_i;
  assign byte_taken = res_dvalid_o & res_dready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: if (cmd_valid_i) begin
        if (err) state_d = ST_ERR;
        else if (cmd_i.is_rd) state_d = ST_RD_LEN;
        else if (nwords == 16'd0) state_d = ST_DONE;
        else state_d = ST_WR_POP;
      end
      ST_WR_POP:  if (word_taken && wcnt_q == 16'd1) state_d = ST_DONE;
      ST_RD_LEN:  if (res_ready_i) state_d = ST_RD_DATA;
      ST_RD_DATA: if (byte_taken && bcnt_q == 2'd3) state_d = ST_DONE;
      ST_ERR:     state_d = ST_DONE;
      ST_DONE:    state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      wcnt_q   <= '0;
      bcnt_q   <= '0;
      req_q    <= 1'b0;
      pavail_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE) wcnt_q <= nwords;
      else if (word_taken) wcnt_q <= wcnt_q - 16'd1;
      if (state_q == ST_IDLE) bcnt_q <= '0;
      else if (byte_taken) bcnt_q <= bcnt_q + 2'd1;
      // Next request only once the previous ack has fallen
      if (state_q != ST_WR_POP || word_taken) req_q <= 1'b0;
      else if (!req_q && !rx_ack_i) req_q <= 1'b1;
      if (state_q == ST_DONE && fifo_wr && status == PROTOCOL_OK) pavail_q <= 1'b1;
      else if (payload_ack_i) pavail_q <= 1'b0;
    end
  end

  assign cmd_done_o = (state_q == ST_DONE);
  assign rx_req_o   = req_q;
  assign rx_clr_o   = (state_q == ST_ERR);

  // Payload words go to the target, status goes to DEVICE_STATUS at done
  assign reg_we_o    = (word_taken & writable) | (state_q == ST_DONE);
  assign reg_wsel_o  = (state_q == ST_DONE) ? CSR_DEVICE_STATUS : csr;
  assign reg_wdata_o = (state_q == ST_DONE) ? {16'h0000, status, 8'h00} : rx_word_i.data;
  assign reg_rsel_o  = csr;

  assign res_valid_o  = (state_q == ST_RD_LEN);
  assign res_len_o    = 16'(REG_BYTES);
  assign res_dvalid_o = (state_q == ST_RD_DATA);
  assign res_byte_o   = '{data: reg_rdata_i[bcnt_q*8 +: 8], last: (bcnt_q == 2'd3)};

  assign payload_available_o = pavail_q;

endmodule

`default_nettype wire

//--- src/recovery_proto_pkg.sv
// Recovery protocol definitions: opcodes, register selector, status codes, lengths
`default_nettype none

package recovery_proto_pkg;

  // Recovery opcodes kept from the recovery spec
  typedef enum logic [7:0] {
    CMD_PROT_CAP           = 8'd34,
    CMD_DEVICE_STATUS      = 8'd36,
    CMD_RECOVERY_CTRL      = 8'd38,
    CMD_INDIRECT_FIFO_CTRL = 8'd45,
    CMD_INDIRECT_FIFO_DATA = 8'd47
  } rec_cmd_e;

  // Register selector between executor and register file
  typedef enum logic [2:0] {
    CSR_PROT_CAP           = 3'd0,
    CSR_DEVICE_STATUS      = 3'd1,
    CSR_RECOVERY_CTRL      = 3'd2,
    CSR_INDIRECT_FIFO_CTRL = 3'd3,
    CSR_INDIRECT_FIFO_DATA = 3'd4,
    CSR_INVALID            = 3'd7
  } rec_csr_e;

  // Protocol status, reported in DEVICE_STATUS byte 1
  typedef enum logic [7:0] {
    PROTOCOL_OK              = 8'h00,
    PROTOCOL_ERROR_READ_ONLY = 8'h01,
    PROTOCOL_ERROR_PARAMETER = 8'h02,
    PROTOCOL_ERROR_LENGTH    = 8'h03
  } rec_status_e;

  // Every kept register is one 32-bit word
  localparam int unsigned REG_BYTES = 4;

endpackage

`default_nettype wire

//--- src/recovery_receiver.sv
// Recovery receiver: parses input frames into commands and packs payload words
`default_nettype none

module recovery_receiver #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           in_valid_i,
  input  recovery_bus_pkg::rec_in_byte_t in_byte_i,
  output logic                           in_ready_o,
  output logic                           push_o,
  output recovery_bus_pkg::rec_word_t    push_word_o,
  input  logic                           full_i,
  output logic                           cmd_valid_o,
  output recovery_bus_pkg::rec_cmd_t     cmd_o,
  input  logic                           cmd_done_i
);
  import recovery_proto_pkg::*;
  import recovery_bus_pkg::*;

  localparam logic [15:0] MAX_LEN = 16'(4 * FIFO_DEPTH);

  typedef enum logic [2:0] {
    ST_CODE,
    ST_DIR,
    ST_LEN_LO,
    ST_LEN_HI,
    ST_PAYLOAD,
    ST_PENDING
  } state_e;

  state_e      state_q;
  rec_cmd_t    cmd_q;
  logic [15:0] cnt_q;
  logic [31:0] wbuf_q;
  logic [31:0] word_nxt;
  logic [15:0] len_nxt;
  logic        en_q;
  logic        accept;
  logic        too_big;
  logic        keep;

  // Stalls while the queue is full or a command is pending
  assign in_ready_o = en_q & ~full_i & (state_q != ST_PENDING);
  assign accept     = in_valid_i & in_ready_o;

  assign too_big = cmd_q.len > MAX_LEN;
  // Bytes past the declared length are dropped, so the queue never overflows
  assign keep    = ~too_big & (cnt_q < cmd_q.len);
  assign len_nxt = {in_byte_i.data, cmd_q.len[7:0]};

  always_comb begin
    word_nxt = wbuf_q;
    word_nxt[cnt_q[1:0]*8 +: 8] = in_byte_i.data;
  end

  // Push on a full word or on the final declared byte
  assign push_o = accept & (state_q == ST_PAYLOAD) & keep &
                  ((cnt_q[1:0] == 2'd3) | (cnt_q == cmd_q.len - 16'd1));
  assign push_word_o = '{data: word_nxt};

  assign cmd_valid_o = (state_q == ST_PENDING);
  assign cmd_o       = cmd_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_CODE;
      cmd_q   <= '0;
      cnt_q   <= '0;
      en_q    <= 1'b0;
    end else begin
      en_q <= 1'b1;
      unique case (state_q)
        ST_CODE: if (accept) begin
          cmd_q.code    <= rec_cmd_e'(in_byte_i.data);
          cmd_q.is_rd   <= 1'b0;
          cmd_q.len     <= '0;
          cmd_q.len_err <= in_byte_i.last;
          cnt_q         <= '0;
          state_q       <= in_byte_i.last ? ST_PENDING : ST_DIR;
        end
        ST_DIR: if (accept) begin
          cmd_q.is_rd <= in_byte_i.data[0];
          if (in_byte_i.last) begin
            // A write frame needs its length field
            cmd_q.len_err <= ~in_byte_i.data[0];
            state_q       <= ST_PENDING;
          end else begin
            state_q <= ST_LEN_LO;
          end
        end
        ST_LEN_LO: if (accept) begin
          cmd_q.len[7:0] <= in_byte_i.data;
          cmd_q.len_err  <= in_byte_i.last;
          state_q        <= in_byte_i.last ? ST_PENDING : ST_LEN_HI;
        end
        ST_LEN_HI: if (accept) begin
          cmd_q.len[15:8] <= in_byte_i.data;
          // Ending here means zero payload bytes
          cmd_q.len_err   <= in_byte_i.last & (len_nxt != 16'd0);
          state_q         <= in_byte_i.last ? ST_PENDING : ST_PAYLOAD;
        end
        ST_PAYLOAD: if (accept) begin
          cnt_q <= cnt_q + 16'd1;
          if (in_byte_i.last) begin
            cmd_q.len_err <= too_big | (cnt_q + 16'd1 != cmd_q.len);
            state_q       <= ST_PENDING;
          end
        end
        ST_PENDING: if (cmd_done_i) state_q <= ST_CODE;
        default: state_q <= ST_CODE;
      endcase
    end
  end

  // Word assembly, zero padded for a partial final word
  always_ff @(posedge clk_i) begin
    if (state_q == ST_CODE) begin
      wbuf_q <= '0;
    end else if (accept && state_q == ST_PAYLOAD && keep) begin
      wbuf_q <= push_o ? '0 : word_nxt;
    end
  end

endmodule

`default_nettype wire

//--- src/recovery_regfile.sv
// Recovery register file: status, control and payload words with read mux
`default_nettype none

module recovery_regfile #(
  parameter logic [31:0] PROT_CAP_VALUE = 32'h0000_0000
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         we_i,
  input  recovery_proto_pkg::rec_csr_e wsel_i,
  input  logic [31:0]                  wdata_i,
  input  recovery_proto_pkg::rec_csr_e rsel_i,
  output logic [31:0]                  rdata_o,
  output logic                         image_activated_o
);
  import recovery_proto_pkg::*;

  logic [31:0] dev_status_q;
  logic [31:0] rec_ctrl_q;
  logic [31:0] fifo_ctrl_q;
  logic [31:0] fifo_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_status_q <= '0;
      rec_ctrl_q   <= '0;
      fifo_ctrl_q  <= '0;
      fifo_data_q  <= '0;
    end else if (we_i) begin
      unique case (wsel_i)
        CSR_DEVICE_STATUS:      dev_status_q <= wdata_i;
        CSR_RECOVERY_CTRL:      rec_ctrl_q   <= wdata_i;
        CSR_INDIRECT_FIFO_CTRL: fifo_ctrl_q  <= wdata_i;
        // Keeps only the most recent payload word
        CSR_INDIRECT_FIFO_DATA: fifo_data_q  <= wdata_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    unique case (rsel_i)
      CSR_PROT_CAP:           rdata_o = PROT_CAP_VALUE;
      CSR_DEVICE_STATUS:      rdata_o = dev_status_q;
      CSR_RECOVERY_CTRL:      rdata_o = rec_ctrl_q;
      CSR_INDIRECT_FIFO_CTRL: rdata_o = fifo_ctrl_q;
      CSR_INDIRECT_FIFO_DATA: rdata_o = fifo_data_q;
      default:                rdata_o = '0;
    endcase
  end

  // Activate image when RECOVERY_CTRL byte 2 holds 0x0F
  assign image_activated_o = (rec_ctrl_q[23:16] == 8'h0F);

endmodule

`default_nettype wire

//--- src/recovery_rx_queue.sv
// Recovery payload queue: circular word buffer with a four-phase pop port
`default_nettype none

module recovery_rx_queue #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        push_i,
  input  recovery_bus_pkg::rec_word_t push_word_i,
  output logic                        full_o,
  input  logic                        rx_req_i,
  output logic                        rx_ack_o,
  output recovery_bus_pkg::rec_word_t rx_word_o,
  input  logic                        clr_i
);
  import recovery_bus_pkg::*;

  localparam int unsigned AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

  rec_word_t       mem_q [FIFO_DEPTH];
  logic [AW-1:0]   wptr_q, rptr_q;
  logic [CW-1:0]   cnt_q;
  logic            ack_q;
  logic            do_push, do_pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + AW'(1);
  endfunction

  assign full_o    = (cnt_q == CW'(FIFO_DEPTH));
  assign do_push   = push_i & ~full_o;
  // Pop once the executor has dropped its request
  assign do_pop    = ack_q & ~rx_req_i;
  assign rx_ack_o  = ack_q;
  assign rx_word_o = mem_q[rptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
      ack_q  <= 1'b0;
    end else if (clr_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
      ack_q  <= 1'b0;
    end else begin
      if (do_push) wptr_q <= next_ptr(wptr_q);
      if (do_pop) rptr_q <= next_ptr(rptr_q);
      cnt_q <= cnt_q + CW'(do_push) - CW'(do_pop);
      // Ack phase tracker
      if (do_pop) ack_q <= 1'b0;
      else if (rx_req_i && cnt_q != '0) ack_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wptr_q] <= push_word_i;
  end

endmodule

`default_nettype wire

//--- src/recovery_top.sv
// Recovery target top level: receiver, payload queue, executor and registers
`default_nettype none

module recovery_top #(
  parameter int unsigned FIFO_DEPTH     = 4,
  parameter logic [31:0] PROT_CAP_VALUE = 32'h0000_0C3A
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            in_valid_i,
  input  recovery_bus_pkg::rec_in_byte_t  in_byte_i,
  output logic                            in_ready_o,
  output logic                            res_valid_o,
  input  logic                            res_ready_i,
  output logic [15:0]                     res_len_o,
  output logic                            res_dvalid_o,
  input  logic                            res_dready_i,
  output recovery_bus_pkg::rec_res_byte_t res_byte_o,
  input  logic                            payload_ack_i,
  output logic                            payload_available_o,
  output logic                            image_activated_o
);
  import recovery_proto_pkg::*;
  import recovery_bus_pkg::*;

  rec_cmd_t    cmd;
  logic        cmd_valid, cmd_done;
  rec_word_t   push_word, rx_word;
  logic        push, full;
  logic        rx_req, rx_ack, rx_clr;
  logic        reg_we;
  rec_csr_e    reg_wsel, reg_rsel;
  logic [31:0] reg_wdata, reg_rdata;

  recovery_receiver #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_receiver (
    .clk_i, .rst_ni, .in_valid_i, .in_byte_i, .in_ready_o,
    .push_o(push), .push_word_o(push_word), .full_i(full),
    .cmd_valid_o(cmd_valid), .cmd_o(cmd), .cmd_done_i(cmd_done)
  );

  recovery_rx_queue #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_rx_queue (
    .clk_i, .rst_ni, .push_i(push), .push_word_i(push_word), .full_o(full),
    .rx_req_i(rx_req), .rx_ack_o(rx_ack), .rx_word_o(rx_word), .clr_i(rx_clr)
  );

  recovery_executor u_executor (
    .clk_i, .rst_ni, .cmd_valid_i(cmd_valid), .cmd_i(cmd), .cmd_done_o(cmd_done),
    .rx_req_o(rx_req), .rx_ack_i(rx_ack), .rx_word_i(rx_word), .rx_clr_o(rx_clr),
    .reg_we_o(reg_we), .reg_wsel_o(reg_wsel), .reg_wdata_o(reg_wdata),
    .reg_rsel_o(reg_rsel), .reg_rdata_i(reg_rdata),
    .res_valid_o, .res_ready_i, .res_len_o, .res_dvalid_o, .res_dready_i, .res_byte_o,
    .payload_ack_i, .payload_available_o
  );

  recovery_regfile #(
    .PROT_CAP_VALUE(PROT_CAP_VALUE)
  ) u_regfile (
    .clk_i, .rst_ni, .we_i(reg_we), .wsel_i(reg_wsel), .wdata_i(reg_wdata),
    .rsel_i(reg_rsel), .rdata_o(reg_rdata), .image_activated_o
  );

endmodule

`default_nettype wire

//--- tests/recovery_top_tb.sv
// Recovery target testbench: drives command frames, checks responses, status and flags
`default_nettype none

module recovery_top_tb;
  import recovery_proto_pkg::*;
  import recovery_bus_pkg::*;

  localparam logic [31:0] PROT_CAP       = 32'h5A0C_3A17;
  localparam int          NUM_FRAMES     = 28;
  localparam int          MAX_FRAME_LEN  = 24;
  localparam int          TIMEOUT_CYCLES = NUM_FRAMES * MAX_FRAME_LEN * 40;

  logic          clk_i;
  logic          rst_ni;
  logic          in_valid_i;
  rec_in_byte_t  in_byte_i;
  logic          in_ready_o;
  logic          res_valid_o;
  logic          res_ready_i;
  logic [15:0]   res_len_o;
  logic          res_dvalid_o;
  logic          res_dready_i;
  rec_res_byte_t res_byte_o;
  logic          payload_ack_i;
  logic          payload_available_o;
  logic          image_activated_o;

  // Reference model of the register contents
  logic [31:0] exp_rc;
  logic [31:0] exp_fc;
  logic [7:0]  status_q;
  logic        exp_pavail;
  logic [7:0]  frame_q[$];
  int          mismatches;
  int          failures;
  integer      seed = 11;

  recovery_top #(
    .FIFO_DEPTH(4),
    .PROT_CAP_VALUE(PROT_CAP)
  ) u_recovery_top (
    .clk_i, .rst_ni, .in_valid_i, .in_byte_i, .in_ready_o,
    .res_valid_o, .res_ready_i, .res_len_o, .res_dvalid_o, .res_dready_i, .res_byte_o,
    .payload_ack_i, .payload_available_o, .image_activated_o
  );

  always #4 clk_i = ~clk_i;

  // Random back-pressure on the response bytes
  always @(posedge clk_i) res_dready_i <= 1'($random(seed));

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      mismatches++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      failures++;
      $display("%s", msg);
    end
  endtask

  function automatic logic [31:0] model_word(input logic [7:0] code);
    case (code)
      CMD_PROT_CAP:           return PROT_CAP;
      CMD_DEVICE_STATUS:      return {16'h0000, status_q, 8'h00};
      CMD_RECOVERY_CTRL:      return exp_rc;
      CMD_INDIRECT_FIFO_CTRL: return exp_fc;
      default:                return 32'h0;
    endcase
  endfunction

  // One byte per accepted transfer, last on the final byte
  task automatic send_frame();
    @(posedge clk_i);
    for (int i = 0; i < frame_q.size(); i++) begin
      in_valid_i <= 1'b1;
      in_byte_i  <= '{data: frame_q[i], last: (i == frame_q.size() - 1)};
      do begin
        @(negedge clk_i);
      end while (!in_ready_o);
      @(posedge clk_i);
    end
    in_valid_i <= 1'b0;
  endtask

  // Command end is the next rise of in_ready_o
  task automatic wait_done(output bit saw_res);
    saw_res = 1'b0;
    do begin
      @(negedge clk_i);
      if (res_valid_o || res_dvalid_o) saw_res = 1'b1;
    end while (!in_ready_o);
  endtask

  task automatic read_reg(input logic [7:0] code, input string name);
    logic [31:0] exp;
    int          lat;
    int          nb;
    bit          saw;
    exp = model_word(code);
    lat = 0;
    nb  = 0;
    frame_q.delete();
    frame_q.push_back(code);
    frame_q.push_back(8'h01);
    send_frame();
    do begin
      @(negedge clk_i);
      lat++;
    end while (!res_valid_o);
    check_value({name, " latency"}, 32'd2, 32'(lat));
    check_value({name, " length"}, 32'd4, {16'h0000, res_len_o});
    // LSB first, stalls follow res_dready_i
    while (nb < 4) begin
      @(negedge clk_i);
      if (res_dvalid_o && res_dready_i) begin
        check_value($sformatf("%s byte %0d", name, nb), {24'h0, exp[nb*8 +: 8]},
                    {24'h0, res_byte_o.data});
        check_value($sformatf("%s last %0d", name, nb), 32'(nb == 3), 32'(res_byte_o.last));
        nb++;
      end
    end
    @(posedge clk_i);
    wait_done(saw);
    status_q = PROTOCOL_OK;
  endtask

  task automatic read_err(input logic [7:0] code, input string name);
    bit saw;
    frame_q.delete();
    frame_q.push_back(code);
    frame_q.push_back(8'h01);
    send_frame();
    wait_done(saw);
    check_true(!saw, {"Unexpected response for ", name});
    status_q = PROTOCOL_ERROR_PARAMETER;
  endtask

  task automatic write_cmd(input logic [7:0] code, input int decl, input int nsent,
                           input logic [31:0] w, input logic [7:0] exp_st, input string name);
    bit saw;
    frame_q.delete();
    frame_q.push_back(code);
    frame_q.push_back(8'h00);
    frame_q.push_back(decl[7:0]);
    frame_q.push_back(decl[15:8]);
    for (int k = 0; k < nsent; k++) begin
      frame_q.push_back(w[(k % 4) * 8 +: 8] ^ 8'(k / 4 * 8'h3C));
    end
    send_frame();
    wait_done(saw);
    check_true(!saw, {"Unexpected response for ", name});
    if (exp_st == PROTOCOL_OK) begin
      if (code == CMD_RECOVERY_CTRL) exp_rc = w;
      if (code == CMD_INDIRECT_FIFO_CTRL) exp_fc = w;
      if (code == CMD_INDIRECT_FIFO_DATA) exp_pavail = 1'b1;
    end
    status_q = exp_st;
    check_value({name, " image"}, 32'(exp_rc[23:16] == 8'h0F), 32'(image_activated_o));
    check_value({name, " payload"}, 32'(exp_pavail), 32'(payload_available_o));
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: the DUT stopped making progress before the tests ended");
    $display("Test failed");
    $finish;
  end

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    in_valid_i    = 1'b0;
    in_byte_i     = '0;
    res_ready_i   = 1'b1;
    res_dready_i  = 1'b0;
    payload_ack_i = 1'b0;
    exp_rc        = '0;
    exp_fc        = '0;
    status_q      = PROTOCOL_OK;
    exp_pavail    = 1'b0;
    mismatches    = 0;
    failures      = 0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    read_reg(CMD_PROT_CAP, "prot_cap read");
    read_reg(CMD_DEVICE_STATUS, "initial status");

    write_cmd(CMD_RECOVERY_CTRL, 4, 4, 32'hA5C3_1E27, PROTOCOL_OK, "rc write a");
    read_reg(CMD_RECOVERY_CTRL, "rc read a");
    write_cmd(CMD_RECOVERY_CTRL, 4, 4, 32'h120F_3456, PROTOCOL_OK, "rc activate");
    read_reg(CMD_RECOVERY_CTRL, "rc read b");

    write_cmd(CMD_PROT_CAP, 4, 4, 32'hFFFF_FFFF, PROTOCOL_ERROR_READ_ONLY, "prot_cap write");
    read_reg(CMD_DEVICE_STATUS, "read-only status");
    read_reg(CMD_PROT_CAP, "prot_cap unchanged");

    // Length errors, each must flush the queue
    write_cmd(CMD_INDIRECT_FIFO_CTRL, 4, 6, 32'h1111_2222, PROTOCOL_ERROR_LENGTH, "fc count");
    read_reg(CMD_DEVICE_STATUS, "count status");
    read_reg(CMD_INDIRECT_FIFO_CTRL, "fc after count");
    write_cmd(CMD_INDIRECT_FIFO_CTRL, 20, 20, 32'h3333_4444, PROTOCOL_ERROR_LENGTH, "fc big");
    read_reg(CMD_DEVICE_STATUS, "big status");
    read_reg(CMD_INDIRECT_FIFO_CTRL, "fc after big");
    write_cmd(CMD_INDIRECT_FIFO_CTRL, 3, 3, 32'h0055_6677, PROTOCOL_ERROR_LENGTH, "fc short");
    read_reg(CMD_DEVICE_STATUS, "short status");
    read_reg(CMD_INDIRECT_FIFO_CTRL, "fc after short");
    write_cmd(CMD_INDIRECT_FIFO_CTRL, 4, 4, 32'h89AB_CDEF, PROTOCOL_OK, "fc valid");
    read_reg(CMD_INDIRECT_FIFO_CTRL, "fc read");

    read_err(8'h55, "unknown code");
    read_reg(CMD_DEVICE_STATUS, "unknown status");
    read_err(CMD_INDIRECT_FIFO_DATA, "fifo data read");
    read_reg(CMD_DEVICE_STATUS, "fifo read status");

    write_cmd(CMD_INDIRECT_FIFO_DATA, 9, 9, 32'hDEAD_BEEF, PROTOCOL_OK, "fd payload");
    read_reg(CMD_DEVICE_STATUS, "fd status");
    @(posedge clk_i);
    payload_ack_i <= 1'b1;
    @(posedge clk_i);
    payload_ack_i <= 1'b0;
    exp_pavail = 1'b0;
    @(negedge clk_i);
    check_value("payload ack", 32'(exp_pavail), 32'(payload_available_o));
    write_cmd(CMD_INDIRECT_FIFO_DATA, 8, 5, 32'h0BAD_F00D, PROTOCOL_ERROR_LENGTH, "fd bad");
    read_reg(CMD_DEVICE_STATUS, "fd bad status");

    $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
